/* ioSubsystem.f */
rtl/ioPkg.sv
rtl/accessAlignment.sv
rtl/loadDataAlignment.sv
rtl/busMaster.sv
rtl/scratchRam.sv
rtl/ioSubsystem.sv
test/ioSubsystemTb.sv

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module ioSubsystemTb \
    -f ioSubsystem.f \
    --Mdir obj_dir \
    -o ioSubsystemSim

./obj_dir/ioSubsystemSim | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
    echo "run.sh: simulation passed"
    exit 0
fi

echo "run.sh: simulation failed, see sim.log"
exit 1

/* test/ioSubsystemTb.sv */
`timescale 1ns/1ps
`default_nettype none

module ioSubsystemTb;

    localparam int ResetCycles = 16;
    localparam int NumAccesses = 128 + 37 + 200;   // Fill, directed, random
    localparam int DoneTimeout = 8;

    // Opcode is {store, unsigned, size}
    localparam logic [3:0] LoadByte   = 4'b0000;
    localparam logic [3:0] LoadHalf   = 4'b0001;
    localparam logic [3:0] LoadWord   = 4'b0010;
    localparam logic [3:0] LoadQuad   = 4'b0011;
    localparam logic [3:0] LoadByteU  = 4'b0100;
    localparam logic [3:0] LoadHalfU  = 4'b0101;
    localparam logic [3:0] StoreByte  = 4'b1000;
    localparam logic [3:0] StoreHalf  = 4'b1001;
    localparam logic [3:0] StoreWord  = 4'b1010;
    localparam logic [3:0] StoreQuad  = 4'b1011;

    logic                        clk;
    logic                        rstN;
    logic                        reqValid;
    logic [3:0]                  minorOpcode;
    logic [ioPkg::AddrWidth-1:0] addr;
    logic [ioPkg::DataWidth-1:0] storeData;
    logic                        ready;
    logic                        done;
    logic                        fault;
    logic [ioPkg::DataWidth-1:0] loadData;

    logic [7:0] refMem [4096];                     // One entry per byte address
    logic [3:0] donePipe;
    logic [3:0] faultPipe;
    int         valueErrors = 0;
    int         timingErrors = 0;

    ioSubsystem dut_i (
        .clk         (clk),
        .rstN        (rstN),
        .reqValid    (reqValid),
        .minorOpcode (minorOpcode),
        .addr        (addr),
        .storeData   (storeData),
        .ready       (ready),
        .done        (done),
        .fault       (fault),
        .loadData    (loadData)
    );

    initial begin : clockGen
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin : watchdog
        repeat (ResetCycles + NumAccesses * 10) @(posedge clk);
        $display("Timeout: the run hung and did not finish within %0d cycles",
                 ResetCycles + NumAccesses * 10);
        $display("SIMULATION FAILED");
        $finish;
    end

    function automatic bit isMisaligned(input logic [3:0] op, input logic [11:0] a);
        case (op[1:0])
            ioPkg::SizeByte: return 1'b0;
            ioPkg::SizeHalf: return a[0];
            default:         return a[1:0] != 2'b00;
        endcase
    endfunction

    // Lane k holds the byte at address offset k
    function automatic logic [31:0] predictLoad(input logic [3:0] op, input logic [11:0] a);
        logic [7:0]  b;
        logic [15:0] h;
        b = refMem[a];
        h = {refMem[a + 12'd1], refMem[a]};
        if (op[ioPkg::OpStoreBit] || isMisaligned(op, a)) begin
            return 32'd0;
        end
        case (op[1:0])
            ioPkg::SizeByte: return op[ioPkg::OpUnsignedBit] ? {24'd0, b} : {{24{b[7]}}, b};
            ioPkg::SizeHalf: return op[ioPkg::OpUnsignedBit] ? {16'd0, h} : {{16{h[15]}}, h};
            default:         return {refMem[a + 12'd3], refMem[a + 12'd2], h};
        endcase
    endfunction

    function automatic void updateReference(input logic [3:0] op, input logic [11:0] a,
                                            input logic [31:0] d);
        if (!op[ioPkg::OpStoreBit] || isMisaligned(op, a)) begin
            return;                                // Faulted stores leave memory alone
        end
        refMem[a] = d[7:0];
        if (op[1:0] != ioPkg::SizeByte) begin
            refMem[a + 12'd1] = d[15:8];
        end
        if (op[1]) begin
            refMem[a + 12'd2] = d[23:16];
            refMem[a + 12'd3] = d[31:24];
        end
    endfunction

    task automatic runAccess(input logic [3:0] op, input logic [11:0] a,
                             input logic [31:0] d, input bit hold);
        logic [31:0] expected;
        int          waitCycles;
        expected = predictLoad(op, a);
        @(posedge clk);
        reqValid    <= 1'b1;
        minorOpcode <= op;
        addr        <= a;
        storeData   <= d;
        @(negedge clk);
        while (!ready) begin
            @(negedge clk);
        end
        @(posedge clk);                            // Taken on this edge
        if (!hold) begin
            reqValid <= 1'b0;
        end
        waitCycles = 0;
        @(negedge clk);
        while (!done && waitCycles < DoneTimeout) begin
            waitCycles++;
            @(negedge clk);
        end
        if (!done) begin
            timingErrors++;
            $display("No done came within %0d cycles for opcode %h at address %h",
                     DoneTimeout, op, a);
        end else begin
            assert (loadData == expected) else begin
                valueErrors++;
                $display("[ERROR] loadData opcode %h addr %h: expected %h, got %h",
                         op, a, expected, loadData);
            end
        end
        if (hold) begin
            @(posedge clk);
            reqValid <= 1'b0;
        end
        updateReference(op, a, d);
    endtask

    // Bit 0 holds the expected done and fault of the current sample
    always @(negedge clk) begin : timingMonitor
        if (rstN !== 1'b1) begin
            donePipe  = '0;
            faultPipe = '0;
        end else begin
            assert (done == donePipe[0]) else begin
                timingErrors++;
                $display("[ERROR] done: expected %h, got %h at %0t", donePipe[0], done, $time);
            end
            assert (fault == faultPipe[0]) else begin
                timingErrors++;
                $display("[ERROR] fault: expected %h, got %h at %0t", faultPipe[0], fault, $time);
            end
            assert (ready == (donePipe == 4'd0)) else begin
                timingErrors++;
                $display("[ERROR] ready: expected %h, got %h at %0t",
                         donePipe == 4'd0, ready, $time);
            end
            donePipe  = donePipe >> 1;
            faultPipe = faultPipe >> 1;
            if (ready && reqValid) begin
                if (isMisaligned(minorOpcode, addr)) begin
                    donePipe[0]  = 1'b1;
                    faultPipe[0] = 1'b1;
                end else begin
                    donePipe[2] = 1'b1;            // Three samples after acceptance
                end
            end
        end
    end

    initial begin : mainSequence
        logic [31:0] randomValue;
        void'($urandom(32'h1e6f85e1));
        rstN        = 1'b0;
        reqValid    = 1'b0;
        minorOpcode = '0;
        addr        = '0;
        storeData   = '0;
        repeat (ResetCycles) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        assert (ready && !done && !fault) else begin
            timingErrors++;
            $display("[ERROR] ready/done/fault after reset: expected 1/0/0, got %h/%h/%h",
                     ready, done, fault);
        end

        // Known contents for the whole test window
        for (int i = 0; i < 128; i++) begin
            runAccess(StoreWord, 12'(i * 4), $urandom, 1'b0);
        end

        for (int off = 0; off < 4; off++) begin
            runAccess(StoreByte, 12'h100 + 12'(off), 32'h5A5A5AC0 + 32'(off), 1'b0);
            runAccess(LoadWord, 12'h100, 32'd0, 1'b0);
        end
        for (int off = 0; off < 4; off += 2) begin
            runAccess(StoreHalf, 12'h104 + 12'(off), 32'hDEAD8000 + 32'(off), 1'b0);
            runAccess(LoadWord, 12'h104, 32'd0, 1'b0);
        end

        // Byte values 8e 7f f1 80 and halves 7f8e 80f1
        runAccess(StoreWord, 12'h110, 32'h80F17F8E, 1'b0);
        for (int off = 0; off < 4; off++) begin
            runAccess(LoadByte, 12'h110 + 12'(off), 32'd0, 1'b0);
            runAccess(LoadByteU, 12'h110 + 12'(off), 32'd0, 1'b0);
        end
        for (int off = 0; off < 4; off += 2) begin
            runAccess(LoadHalf, 12'h110 + 12'(off), 32'd0, 1'b0);
            runAccess(LoadHalfU, 12'h110 + 12'(off), 32'd0, 1'b0);
        end

        runAccess(StoreHalf, 12'h121, 32'hFFFFFFFF, 1'b0);
        runAccess(StoreWord, 12'h122, 32'hFFFFFFFF, 1'b0);
        runAccess(StoreQuad, 12'h123, 32'hFFFFFFFF, 1'b0);
        runAccess(LoadWord, 12'h121, 32'd0, 1'b0);
        runAccess(LoadHalf, 12'h127, 32'd0, 1'b0);
        runAccess(LoadWord, 12'h120, 32'd0, 1'b0);
        runAccess(LoadWord, 12'h124, 32'd0, 1'b0);

        runAccess(StoreQuad, 12'h130, 32'hC001D00D, 1'b0);
        runAccess(LoadWord, 12'h130, 32'd0, 1'b0);
        runAccess(LoadQuad, 12'h130, 32'd0, 1'b0);
        runAccess(StoreWord, 12'h134, 32'h13572468, 1'b1);   // reqValid held while busy
        runAccess(LoadQuad, 12'h134, 32'd0, 1'b1);

        for (int n = 0; n < 200; n++) begin
            randomValue = $urandom;
            runAccess(randomValue[3:0], {3'b000, randomValue[12:4]}, $urandom, 1'b0);
        end

        repeat (4) @(posedge clk);
        $display("Summary: %0d value errors, %0d timing errors", valueErrors, timingErrors);
        if (valueErrors + timingErrors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/ioSubsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module ioSubsystem (
    input  wire logic                         clk,
    input  wire logic                         rstN,

    input  wire logic                         reqValid,
    input  wire logic [3:0]                   minorOpcode,
    input  wire logic [ioPkg::AddrWidth-1:0]  addr,
    input  wire logic [ioPkg::DataWidth-1:0]  storeData,

    output      logic                         ready,
    output      logic                         done,
    output      logic                         fault,
    output      logic [ioPkg::DataWidth-1:0]  loadData
);

    logic [ioPkg::ByteLanes-1:0] alignSel;
    logic [ioPkg::DataWidth-1:0] alignWriteData;
    logic                        misaligned;

    logic                        isLoad;
    logic [1:0]                  size;
    logic                        unsignedLoad;
    logic [1:0]                  byteOffset;
    logic [ioPkg::DataWidth-1:0] readWord;
    logic [ioPkg::DataWidth-1:0] alignedLoad;

    logic                        cyc;
    logic                        stb;
    logic                        we;
    logic [ioPkg::AddrWidth-3:0] adr;
    logic [ioPkg::ByteLanes-1:0] busSel;
    logic [ioPkg::DataWidth-1:0] busWriteData;
    logic [ioPkg::DataWidth-1:0] busReadData;
    logic                        ack;

    accessAlignment accessAlignment_i (
        .minorOpcode (minorOpcode),
        .addr        (addr),
        .storeData   (storeData),
        .sel         (alignSel),
        .writeData   (alignWriteData),
        .misaligned  (misaligned)
    );

    busMaster busMaster_i (
        .clk          (clk),
        .rstN         (rstN),
        .reqValid     (reqValid),
        .minorOpcode  (minorOpcode),
        .addr         (addr),
        .sel          (alignSel),
        .writeData    (alignWriteData),
        .misaligned   (misaligned),
        .ready        (ready),
        .done         (done),
        .fault        (fault),
        .isLoad       (isLoad),
        .size         (size),
        .unsignedLoad (unsignedLoad),
        .byteOffset   (byteOffset),
        .readWord     (readWord),
        .ack          (ack),
        .datIn        (busReadData),
        .cyc          (cyc),
        .stb          (stb),
        .we           (we),
        .adr          (adr),
        .selOut       (busSel),
        .datOut       (busWriteData)
    );

    scratchRam scratchRam_i (
        .clk    (clk),
        .rstN   (rstN),
        .cyc    (cyc),
        .stb    (stb),
        .we     (we),
        .adr    (adr),
        .sel    (busSel),
        .datIn  (busWriteData),
        .ack    (ack),
        .datOut (busReadData)
    );

    loadDataAlignment loadDataAlignment_i (
        .size         (size),
        .unsignedLoad (unsignedLoad),
        .byteOffset   (byteOffset),
        .readWord     (readWord),
        .loadData     (alignedLoad)
    );

    assign loadData = isLoad ? alignedLoad : '0;   // Zero on stores and faults

endmodule

`default_nettype wire

/* rtl/scratchRam.sv */
`timescale 1ns/1ps
`default_nettype none

module scratchRam (
    input  wire logic                         clk,
    input  wire logic                         rstN,

    // Wishbone classic slave
    input  wire logic                         cyc,
    input  wire logic                         stb,
    input  wire logic                         we,
    input  wire logic [ioPkg::AddrWidth-3:0]  adr,
    input  wire logic [ioPkg::ByteLanes-1:0]  sel,
    input  wire logic [ioPkg::DataWidth-1:0]  datIn,
    output      logic                         ack,
    output      logic [ioPkg::DataWidth-1:0]  datOut
);

    logic [ioPkg::DataWidth-1:0] mem [ioPkg::RamWords];
    logic                        access;

    // First strobe cycle only, so one ack per bus cycle
    assign access = cyc && stb && !ack;

    always_ff @(posedge clk) begin : ackGen
        if (!rstN) begin
            ack <= 1'b0;
        end else begin
            ack <= access;
        end
    end

    always_ff @(posedge clk) begin : memPort
        if (access) begin
            if (we) begin
                for (int lane = 0; lane < ioPkg::ByteLanes; lane++) begin
                    if (sel[lane]) begin
                        mem[adr][lane*8 +: 8] <= datIn[lane*8 +: 8];
                    end
                end
            end
            datOut <= mem[adr];                    // Valid with ack
        end
    end

endmodule

`default_nettype wire

/* rtl/busMaster.sv */
`timescale 1ns/1ps
`default_nettype none

module busMaster (
    input  wire logic                         clk,
    input  wire logic                         rstN,

    // Core side
    input  wire logic                         reqValid,
    input  wire logic [3:0]                   minorOpcode,
    input  wire logic [ioPkg::AddrWidth-1:0]  addr,
    input  wire logic [ioPkg::ByteLanes-1:0]  sel,
    input  wire logic [ioPkg::DataWidth-1:0]  writeData,
    input  wire logic                         misaligned,
    output      logic                         ready,
    output      logic                         done,
    output      logic                         fault,

    // To load alignment
    output      logic                         isLoad,
    output      logic [1:0]                   size,
    output      logic                         unsignedLoad,
    output      logic [1:0]                   byteOffset,
    output      logic [ioPkg::DataWidth-1:0]  readWord,

    // Wishbone classic master
    input  wire logic                         ack,
    input  wire logic [ioPkg::DataWidth-1:0]  datIn,
    output      logic                         cyc,
    output      logic                         stb,
    output      logic                         we,
    output      logic [ioPkg::AddrWidth-3:0]  adr,
    output      logic [ioPkg::ByteLanes-1:0]  selOut,
    output      logic [ioPkg::DataWidth-1:0]  datOut
);

    logic [1:0] state;
    logic       faultReg;
    logic       accept;

    assign ready  = (state == ioPkg::BusIdle);
    assign accept = ready && reqValid;
    assign done   = (state == ioPkg::BusDone);
    assign fault  = done && faultReg;

    assign cyc = (state == ioPkg::BusCycle);
    assign stb = cyc;
    assign we  = cyc && !isLoad;                   // Aligned non-loads are stores

    always_ff @(posedge clk) begin : controlFsm
        if (!rstN) begin
            state    <= ioPkg::BusIdle;
            faultReg <= 1'b0;
            isLoad   <= 1'b0;
        end else begin
            case (state)
                ioPkg::BusIdle: begin
                    if (reqValid) begin
                        faultReg <= misaligned;
                        // Faulted loads return zero
                        isLoad   <= !minorOpcode[ioPkg::OpStoreBit] && !misaligned;
                        state    <= misaligned ? ioPkg::BusDone : ioPkg::BusCycle;
                    end
                end
                ioPkg::BusCycle: begin
                    if (ack) begin
                        state <= ioPkg::BusDone;   // Drop cyc/stb next cycle
                    end
                end
                default: begin
                    state <= ioPkg::BusIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin : requestCapture
        if (accept) begin
            size         <= minorOpcode[1:0];
            unsignedLoad <= minorOpcode[ioPkg::OpUnsignedBit];
            byteOffset   <= addr[1:0];
            adr          <= addr[ioPkg::AddrWidth-1:2];  // Word address
            selOut       <= sel;
            datOut       <= writeData;
        end
        if (cyc && ack) begin
            readWord <= datIn;
        end
    end

endmodule

`default_nettype wire

/* rtl/loadDataAlignment.sv */
`timescale 1ns/1ps
`default_nettype none

module loadDataAlignment (
    input  wire logic [1:0]                   size,
    input  wire logic                         unsignedLoad,
    input  wire logic [1:0]                   byteOffset,
    input  wire logic [ioPkg::DataWidth-1:0]  readWord,

    output      logic [ioPkg::DataWidth-1:0]  loadData
);

    logic [7:0]  byteSelect;
    logic [15:0] halfSelect;

    always_comb begin : byteSelectMux
        case (byteOffset)
            2'b01:   byteSelect = readWord[15:8];
            2'b10:   byteSelect = readWord[23:16];
            2'b11:   byteSelect = readWord[31:24];
            default: byteSelect = readWord[7:0];
        endcase
    end

    assign halfSelect = byteOffset[1] ? readWord[31:16] : readWord[15:0];

    always_comb begin : extendMux
        case (size)
            ioPkg::SizeByte: begin
                if (unsignedLoad) begin
                    loadData = {24'd0, byteSelect};
                end else begin
                    loadData = {{24{byteSelect[7]}}, byteSelect};  // Sign from bit 7
                end
            end
            ioPkg::SizeHalf: begin
                if (unsignedLoad) begin
                    loadData = {16'd0, halfSelect};
                end else begin
                    loadData = {{16{halfSelect[15]}}, halfSelect};
                end
            end
            default: loadData = readWord;       // Word and quad pass through
        endcase
    end

endmodule

`default_nettype wire

/* rtl/accessAlignment.sv */
`timescale 1ns/1ps
`default_nettype none

module accessAlignment (
    input  wire logic [3:0]                   minorOpcode,
    input  wire logic [ioPkg::AddrWidth-1:0]  addr,
    input  wire logic [ioPkg::DataWidth-1:0]  storeData,

    output      logic [ioPkg::ByteLanes-1:0]  sel,
    output      logic [ioPkg::DataWidth-1:0]  writeData,
    output      logic                         misaligned
);

    logic [1:0] size;
    logic [1:0] byteOffset;

    assign size       = minorOpcode[1:0];
    assign byteOffset = addr[1:0];

    always_comb begin : laneMux
        case (size)
            ioPkg::SizeByte: begin
                sel        = ioPkg::ByteLanes'(1) << byteOffset;
                writeData  = {4{storeData[7:0]}};      // Byte on every lane
                misaligned = 1'b0;
            end
            ioPkg::SizeHalf: begin
                sel        = byteOffset[1] ? 4'b1100 : 4'b0011;
                writeData  = {2{storeData[15:0]}};
                misaligned = byteOffset[0];            // Odd address
            end
            default: begin                             // Word and quad
                sel        = '1;
                writeData  = storeData;
                misaligned = (byteOffset != 2'b00);
            end
        endcase
    end

endmodule

`default_nettype wire

/* rtl/ioPkg.sv */
`default_nettype none

package ioPkg;

    // Data path and address space
    localparam int DataWidth = 32;
    localparam int AddrWidth = 12;                 // Byte address
    localparam int ByteLanes = DataWidth / 8;
    localparam int RamWords  = 1024;

    // Size field, minorOpcode[1:0]
    localparam logic [1:0] SizeByte = 2'd0;
    localparam logic [1:0] SizeHalf = 2'd1;
    localparam logic [1:0] SizeWord = 2'd2;
    localparam logic [1:0] SizeQuad = 2'd3;        // Same as word at 32 bits

    // Flag bits of minorOpcode
    localparam int OpStoreBit    = 3;
    localparam int OpUnsignedBit = 2;

    // busMaster states
    localparam logic [1:0] BusIdle  = 2'd0;
    localparam logic [1:0] BusCycle = 2'd1;
    localparam logic [1:0] BusDone  = 2'd2;

endpackage

`default_nettype wire
